// ==== debug_interface_wb.sv ====
`timescale 1ns/1ps

module debug_interface_wb
    import wb_pkg::*;
(
    input  logic     wb_clk_i,
    input  logic     rst_i,
    input  logic     stb_i,
    input  logic     we_i,
    input  wb_data_t dat_i,
    input  wb_sel_t  sel_i,
    output wb_data_t dat_o,
    output logic     ack_o,
    output wb_data_t dbg_data_o,
    output logic     dbg_valid_o
);

    logic     wr_en;
    wb_data_t mailbox_q;

    assign wr_en = stb_i && we_i;

    always_ff @(posedge wb_clk_i)
    begin
        if (rst_i)
        begin
            mailbox_q   <= '0;
            ack_o       <= 1'b0;
            dbg_valid_o <= 1'b0;
        end
        else
        begin
            ack_o       <= stb_i;
            // host sees the new word together with the pulse
            dbg_valid_o <= wr_en;
            if (wr_en)
            begin
                mailbox_q <= wb_merge_lanes(mailbox_q, dat_i, sel_i);
            end
        end
    end

    // readback of the word at the accepting edge
    always_ff @(posedge wb_clk_i)
    begin
        if (stb_i)
        begin
            dat_o <= mailbox_q;
        end
    end

    assign dbg_data_o = mailbox_q;

endmodule

// ==== memory_2rw_wb.sv ====
`timescale 1ns/1ps

module memory_2rw_wb
    import wb_pkg::*;
#(
    parameter int MEM_ADDR_WIDTH = 13
)
(
    input  logic     wb_clk_i,
    input  logic     rst_i,

    // port 0, fetch only
    input  logic     p0_stb_i,
    input  wb_addr_t p0_adr_i,
    output wb_data_t p0_dat_o,
    output logic     p0_ack_o,

    // port 1, load and store
    input  logic     p1_stb_i,
    input  logic     p1_we_i,
    input  wb_addr_t p1_adr_i,
    input  wb_data_t p1_dat_i,
    input  wb_sel_t  p1_sel_i,
    output wb_data_t p1_dat_o,
    output logic     p1_ack_o
);

    localparam int MEM_WORDS = 2 ** MEM_ADDR_WIDTH;

    wb_data_t                  mem [MEM_WORDS];
    logic [MEM_ADDR_WIDTH-1:0] p0_idx;
    logic [MEM_ADDR_WIDTH-1:0] p1_idx;

    // word index, byte offset dropped
    assign p0_idx = p0_adr_i[MEM_ADDR_WIDTH+1:2];
    assign p1_idx = p1_adr_i[MEM_ADDR_WIDTH+1:2];

    // store, lane by lane
    always_ff @(posedge wb_clk_i)
    begin
        if (p1_stb_i && p1_we_i)
        begin
            for (int b = 0; b < WB_DATA_BYTES; b++)
            begin
                if (p1_sel_i[b])
                begin
                    mem[p1_idx][8*b +: 8] <= p1_dat_i[8*b +: 8];
                end
            end
        end
    end

    // read data shows the word before a same-edge store
    always_ff @(posedge wb_clk_i)
    begin
        if (p0_stb_i)
        begin
            p0_dat_o <= mem[p0_idx];
        end
    end

    always_ff @(posedge wb_clk_i)
    begin
        if (p1_stb_i)
        begin
            p1_dat_o <= mem[p1_idx];
        end
    end

    // one ack per strobe, next cycle
    always_ff @(posedge wb_clk_i)
    begin
        if (rst_i)
        begin
            p0_ack_o <= 1'b0;
            p1_ack_o <= 1'b0;
        end
        else
        begin
            p0_ack_o <= p0_stb_i;
            p1_ack_o <= p1_stb_i;
        end
    end

endmodule

// ==== mtime_registers_wb.sv ====
`timescale 1ns/1ps

module mtime_registers_wb
    import wb_pkg::*;
    import soc_map_pkg::*;
(
    input  logic     wb_clk_i,
    input  logic     rst_i,
    input  logic     stb_i,
    input  logic     we_i,
    input  wb_addr_t adr_i,
    input  wb_data_t dat_i,
    input  wb_sel_t  sel_i,
    output wb_data_t dat_o,
    output logic     ack_o,
    output logic     mtip_o
);

    timer_word_u mtime_q;
    timer_word_u mtimecmp_q;
    timer_word_u mtime_nxt;
    timer_word_u mtimecmp_nxt;
    logic [3:0]  ofs;
    logic        wr_en;
    logic        tmr_written_q;

    assign ofs   = adr_i[3:0];
    assign wr_en = stb_i && we_i;

    // free-running count, a bus write to mtime wins
    always_comb
    begin
        mtime_nxt.count = mtime_q.count + 64'd1;
        mtimecmp_nxt    = mtimecmp_q;
        if (wr_en)
        begin
            case (ofs)
                MTIME_LO_OFS:
                begin
                    mtime_nxt          = mtime_q;
                    mtime_nxt.half.lo  = wb_merge_lanes(mtime_q.half.lo, dat_i, sel_i);
                end
                MTIME_HI_OFS:
                begin
                    mtime_nxt          = mtime_q;
                    mtime_nxt.half.hi  = wb_merge_lanes(mtime_q.half.hi, dat_i, sel_i);
                end
                MTIMECMP_LO_OFS:
                    mtimecmp_nxt.half.lo = wb_merge_lanes(mtimecmp_q.half.lo, dat_i, sel_i);
                MTIMECMP_HI_OFS:
                    mtimecmp_nxt.half.hi = wb_merge_lanes(mtimecmp_q.half.hi, dat_i, sel_i);
                default: ;
            endcase
        end
    end

    always_ff @(posedge wb_clk_i)
    begin
        if (rst_i)
        begin
            mtime_q.count    <= '0;
            mtimecmp_q.count <= MTIMECMP_RESET;
            ack_o            <= 1'b0;
            mtip_o           <= 1'b0;
            tmr_written_q    <= 1'b0;
        end
        else
        begin
            mtime_q    <= mtime_nxt;
            mtimecmp_q <= mtimecmp_nxt;
            ack_o      <= stb_i;
            // full 64-bit compare
            mtip_o     <= (mtime_q.count >= mtimecmp_q.count);
            if (wr_en)
            begin
                tmr_written_q <= 1'b1;
            end
        end
    end

    // read the half selected by the offset
    always_ff @(posedge wb_clk_i)
    begin
        if (stb_i)
        begin
            case (ofs)
                MTIME_LO_OFS:    dat_o <= mtime_q.half.lo;
                MTIME_HI_OFS:    dat_o <= mtime_q.half.hi;
                MTIMECMP_LO_OFS: dat_o <= mtimecmp_q.half.lo;
                MTIMECMP_HI_OFS: dat_o <= mtimecmp_q.half.hi;
                default:         dat_o <= '0;
            endcase
        end
    end

    a_mtip_quiet: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        !tmr_written_q |-> !mtip_o)
        else $error("mtip raised before any timer register write");

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_wb_soc \
    -f verilog.f \
    -o tb_wb_soc
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/tb_wb_soc 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qF -- "*** PASSED ***"; then
    echo "simulation passed"
    exit 0
fi

echo "simulation failed"
exit 1

// ==== soc_map_pkg.sv ====
package soc_map_pkg;

    import wb_pkg::*;

    // machine timer window, four words
    localparam wb_addr_t MTIME_BASE = 32'h0000_8000;
    localparam wb_addr_t MTIME_LAST = MTIME_BASE + 32'h0000_000F;

    // register offsets inside the timer window
    localparam logic [3:0] MTIME_LO_OFS    = 4'h0;
    localparam logic [3:0] MTIME_HI_OFS    = 4'h4;
    localparam logic [3:0] MTIMECMP_LO_OFS = 4'h8;
    localparam logic [3:0] MTIMECMP_HI_OFS = 4'hC;

    // single mailbox word
    localparam wb_addr_t DEBUG_ADR = 32'h0000_8010;

    // compare value out of reset, keeps mtip low
    localparam logic [63:0] MTIMECMP_RESET = 64'hFFFF_FFFF_FFFF_FFFF;

    // two bus words of a 64-bit timer register
    typedef struct packed {
        wb_data_t hi;
        wb_data_t lo;
    } timer_halves_t;

    // count view for arithmetic, halves view for the bus
    typedef union packed {
        logic [63:0]   count;
        timer_halves_t half;
    } timer_word_u;

endpackage

// ==== tb_wb_soc.sv ====
`timescale 1ns/1ps

module tb_wb_soc
    import wb_pkg::*;
    import soc_map_pkg::*;
();

    localparam wb_addr_t RESET_VECTOR   = 32'h0001_0000;
    localparam int       MEM_ADDR_WIDTH = 13;
    localparam int       NWORDS         = 16;
    localparam int       NPIPE          = 24;
    localparam int       IDLE_CYCLES    = 40;
    localparam int       WAIT_LIMIT     = 20;

    logic     wb_clk_i = 1'b0;
    logic     rst_i;
    logic     inst_cyc_i;
    logic     inst_stb_i;
    wb_addr_t inst_adr_i;
    wb_data_t inst_dat_o;
    logic     inst_ack_o;
    logic     inst_err_o;
    logic     data_cyc_i;
    logic     data_stb_i;
    logic     data_we_i;
    wb_addr_t data_adr_i;
    wb_data_t data_dat_i;
    wb_sel_t  data_sel_i;
    wb_data_t data_dat_o;
    logic     data_ack_o;
    logic     data_err_o;
    logic     mtip_o;
    wb_data_t dbg_data_o;
    logic     dbg_valid_o;

    int       errors;
    int       timeouts;
    // memory words under test and their expected contents
    wb_addr_t addrs [NWORDS];
    wb_data_t model [NWORDS];

    wb_soc_top #(
        .RESET_VECTOR   (RESET_VECTOR),
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) wb_soc_top_inst (.*);

    always #50 wb_clk_i = ~wb_clk_i;

    task automatic check_data(input wb_data_t got, input wb_data_t exp, input string what);
        if (timeouts == 0 && got !== exp)
        begin
            errors++;
            $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (timeouts == 0 && got !== exp)
        begin
            errors++;
            $display("mismatch at %0t: %s, got %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_timer(input timer_word_u got, input timer_word_u exp, input string what);
        if (timeouts == 0 && got.count !== exp.count)
        begin
            errors++;
            $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got.count,
                     exp.count);
        end
    endtask

    function automatic wb_data_t lane_mask(input wb_sel_t sel);
        wb_data_t mask;
        for (int b = 0; b < WB_DATA_BYTES; b++)
        begin
            mask[8*b +: 8] = sel[b] ? 8'hFF : 8'h00;
        end
        return mask;
    endfunction

    function automatic wb_addr_t tmr_adr(input logic [3:0] ofs);
        return MTIME_BASE | {28'd0, ofs};
    endfunction

    // one request on the data port, called and returning on a falling edge
    task automatic data_cycle(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                              input wb_sel_t sel, output wb_data_t rdat, output logic err);
        int waited;
        rdat = '0;
        err  = 1'b0;
        if (timeouts != 0)
        begin
            return;
        end
        data_cyc_i = 1'b1;
        data_stb_i = 1'b1;
        data_we_i  = we;
        data_adr_i = adr;
        data_dat_i = wdat;
        data_sel_i = sel;
        @(negedge wb_clk_i);
        data_cyc_i = 1'b0;
        data_stb_i = 1'b0;
        data_we_i  = 1'b0;
        waited = 0;
        while (!data_ack_o && !data_err_o && waited < WAIT_LIMIT)
        begin
            @(negedge wb_clk_i);
            waited++;
        end
        if (!data_ack_o && !data_err_o)
        begin
            $display("data port gave no ack or err for address %h", adr);
            timeouts++;
        end
        else
        begin
            check_bit(waited == 0, 1'b1, "data response after one cycle");
            check_bit(data_ack_o && data_err_o, 1'b0, "data ack together with err");
            rdat = data_dat_o;
            err  = data_err_o;
        end
    endtask

    task automatic data_write(input wb_addr_t adr, input wb_data_t wdat, input wb_sel_t sel,
                              output logic err);
        wb_data_t ignored;
        data_cycle(1'b1, adr, wdat, sel, ignored, err);
    endtask

    task automatic data_read(input wb_addr_t adr, output wb_data_t rdat, output logic err);
        data_cycle(1'b0, adr, '0, 4'hF, rdat, err);
    endtask

    task automatic inst_read(input wb_addr_t adr, output wb_data_t rdat, output logic err);
        int waited;
        rdat = '0;
        err  = 1'b0;
        if (timeouts != 0)
        begin
            return;
        end
        inst_cyc_i = 1'b1;
        inst_stb_i = 1'b1;
        inst_adr_i = adr;
        @(negedge wb_clk_i);
        inst_cyc_i = 1'b0;
        inst_stb_i = 1'b0;
        waited = 0;
        while (!inst_ack_o && !inst_err_o && waited < WAIT_LIMIT)
        begin
            @(negedge wb_clk_i);
            waited++;
        end
        if (!inst_ack_o && !inst_err_o)
        begin
            $display("instruction port gave no ack or err for address %h", adr);
            timeouts++;
        end
        else
        begin
            check_bit(waited == 0, 1'b1, "fetch response after one cycle");
            check_bit(inst_ack_o && inst_err_o, 1'b0, "fetch ack together with err");
            rdat = inst_dat_o;
            err  = inst_err_o;
        end
    endtask

    task automatic wait_mtip(input logic level);
        int waited;
        waited = 0;
        while (timeouts == 0 && mtip_o !== level && waited < WAIT_LIMIT)
        begin
            @(negedge wb_clk_i);
            waited++;
        end
        if (timeouts == 0 && mtip_o !== level)
        begin
            $display("mtip_o did not go to %0b in time", level);
            timeouts++;
        end
    endtask

    task automatic memory_bytes();
        wb_data_t wdat;
        wb_data_t rdat;
        wb_sel_t  sel;
        logic     err;
        int       k;
        // one word per 2 KiB block keeps the addresses distinct
        for (int i = 0; i < NWORDS; i++)
        begin
            addrs[i] = RESET_VECTOR + wb_addr_t'((i * 512 + $urandom_range(0, 511)) * 4);
            model[i] = $urandom;
        end
        // same word index as the unmapped probe at 8000_0100
        addrs[0] = RESET_VECTOR + 32'h100;
        // first and last words, aliased by the probes just outside the window
        addrs[1]          = RESET_VECTOR;
        addrs[NWORDS - 1] = RESET_VECTOR + (32'd4 << MEM_ADDR_WIDTH) - 32'd4;
        for (int i = 0; i < NWORDS; i++)
        begin
            data_write(addrs[i], model[i], 4'hF, err);
            check_bit(err, 1'b0, "err on full memory write");
        end
        repeat (32)
        begin
            k    = $urandom_range(0, NWORDS - 1);
            wdat = $urandom;
            sel  = wb_sel_t'($urandom_range(1, 15));
            data_write(addrs[k], wdat, sel, err);
            check_bit(err, 1'b0, "err on partial memory write");
            model[k] = (model[k] & ~lane_mask(sel)) | (wdat & lane_mask(sel));
        end
        for (int i = 0; i < NWORDS; i++)
        begin
            data_read(addrs[i], rdat, err);
            check_data(rdat, model[i], "memory readback on data port");
            inst_read(addrs[i], rdat, err);
            check_data(rdat, model[i], "memory readback on fetch port");
            check_bit(err, 1'b0, "err on mapped fetch");
        end
    endtask

    task automatic unmapped_access();
        wb_data_t rdat;
        logic     err;
        data_read(32'h8000_0100, rdat, err);
        check_bit(err, 1'b1, "err on unmapped data read");
        check_data(rdat, '0, "data of unmapped read");
        data_write(32'h8000_0100, 32'hDEAD_BEEF, 4'hF, err);
        check_bit(err, 1'b1, "err on unmapped data write");
        data_write(RESET_VECTOR - 32'd4, 32'hDEAD_BEEF, 4'hF, err);
        check_bit(err, 1'b1, "err on write below the memory window");
        // first byte past the window, aliases word 0 of the array
        data_write(RESET_VECTOR + (32'd4 << MEM_ADDR_WIDTH), 32'hDEAD_BEEF, 4'hF, err);
        check_bit(err, 1'b1, "err on write above the memory window");
        inst_read(32'h8000_0000, rdat, err);
        check_bit(err, 1'b1, "err on unmapped fetch");
        for (int i = 0; i < NWORDS; i++)
        begin
            data_read(addrs[i], rdat, err);
            check_data(rdat, model[i], "memory after unmapped writes");
        end
    endtask

    task automatic timer_counting();
        wb_data_t rdat;
        logic     err;
        data_write(tmr_adr(MTIME_LO_OFS), 32'h100, 4'hF, err);
        data_write(tmr_adr(MTIME_HI_OFS), 32'h0, 4'hF, err);
        check_bit(err, 1'b0, "err on mtime write");
        repeat (IDLE_CYCLES) @(negedge wb_clk_i);
        data_read(tmr_adr(MTIME_LO_OFS), rdat, err);
        if (timeouts == 0 && (rdat < 32'h100 + IDLE_CYCLES || rdat > 32'h100 + IDLE_CYCLES + 10))
        begin
            errors++;
            $display("mismatch at %0t: mtime lo %h outside the expected count range",
                     $time, rdat);
        end
        data_read(tmr_adr(MTIME_HI_OFS), rdat, err);
        check_data(rdat, 32'h0, "mtime hi after counting");
    endtask

    task automatic timer_interrupt();
        timer_word_u got;
        timer_word_u exp;
        logic        err;
        check_bit(mtip_o, 1'b0, "mtip with mtimecmp at its reset value");
        data_write(tmr_adr(MTIMECMP_LO_OFS), 32'h0, 4'hF, err);
        data_write(tmr_adr(MTIMECMP_HI_OFS), 32'h0, 4'hF, err);
        wait_mtip(1'b1);
        data_read(tmr_adr(MTIMECMP_LO_OFS), got.half.lo, err);
        data_read(tmr_adr(MTIMECMP_HI_OFS), got.half.hi, err);
        exp.count = 64'h0;
        check_timer(got, exp, "mtimecmp cleared");
        data_write(tmr_adr(MTIMECMP_HI_OFS), 32'hFFFF_FFFF, 4'hF, err);
        wait_mtip(1'b0);
        data_read(tmr_adr(MTIMECMP_LO_OFS), got.half.lo, err);
        data_read(tmr_adr(MTIMECMP_HI_OFS), got.half.hi, err);
        exp.count = 64'hFFFF_FFFF_0000_0000;
        check_timer(got, exp, "mtimecmp with hi set");
    endtask

    task automatic mailbox_write();
        wb_data_t wdat;
        wb_data_t rdat;
        wb_data_t seen;
        logic     err;
        int       pulses;
        wdat = $urandom;
        data_write(DEBUG_ADR, wdat, 4'hF, err);
        check_bit(err, 1'b0, "err on mailbox write");
        // pulse is due at the edge the write returns on
        check_bit(dbg_valid_o, 1'b1, "dbg_valid_o one cycle after the write");
        pulses = 0;
        seen   = '0;
        repeat (4)
        begin
            if (dbg_valid_o)
            begin
                pulses++;
                seen = dbg_data_o;
            end
            @(negedge wb_clk_i);
        end
        check_bit(pulses == 1, 1'b1, "exactly one dbg_valid_o pulse");
        check_data(seen, wdat, "mailbox word with the pulse");
        data_read(DEBUG_ADR, rdat, err);
        check_data(rdat, wdat, "mailbox readback");
        data_write(DEBUG_ADR, 32'h1234_5678, 4'b0010, err);
        data_read(DEBUG_ADR, rdat, err);
        check_data(rdat, {wdat[31:16], 8'h56, wdat[7:0]}, "mailbox lane 1 write");
    endtask

    task automatic pipelined_reads();
        wb_data_t exp_q [$];
        wb_data_t exp_now;
        int       k;
        for (int i = 0; i <= NPIPE; i++)
        begin
            // answer to the strobe of the previous cycle
            if (i > 0)
            begin
                exp_now = exp_q.pop_front();
                check_bit(data_ack_o, 1'b1, "back-to-back ack");
                check_data(data_dat_o, exp_now, "back-to-back read data");
            end
            if (i < NPIPE)
            begin
                data_cyc_i = 1'b1;
                data_stb_i = 1'b1;
                data_we_i  = 1'b0;
                data_sel_i = 4'hF;
                if ($urandom_range(0, 2) == 0)
                begin
                    data_adr_i = tmr_adr(i[0] ? MTIMECMP_HI_OFS : MTIMECMP_LO_OFS);
                    exp_q.push_back(i[0] ? 32'hFFFF_FFFF : 32'h0);
                end
                else
                begin
                    k = $urandom_range(0, NWORDS - 1);
                    data_adr_i = addrs[k];
                    exp_q.push_back(model[k]);
                end
            end
            else
            begin
                data_cyc_i = 1'b0;
                data_stb_i = 1'b0;
            end
            @(negedge wb_clk_i);
        end
        check_bit(data_ack_o, 1'b0, "no ack after the last strobe");
    endtask

    initial
    begin
        void'($urandom(32'hc0f3));
        errors     = 0;
        timeouts   = 0;
        rst_i      = 1'b1;
        inst_cyc_i = 1'b0;
        inst_stb_i = 1'b0;
        inst_adr_i = '0;
        data_cyc_i = 1'b0;
        data_stb_i = 1'b0;
        data_we_i  = 1'b0;
        data_adr_i = '0;
        data_dat_i = '0;
        data_sel_i = '0;
        repeat (10) @(negedge wb_clk_i);
        rst_i = 1'b0;
        @(negedge wb_clk_i);
        check_bit(inst_ack_o | inst_err_o, 1'b0, "fetch response after reset");
        check_bit(data_ack_o | data_err_o, 1'b0, "data response after reset");
        check_bit(dbg_valid_o, 1'b0, "dbg_valid_o after reset");
        check_bit(mtip_o, 1'b0, "mtip_o after reset");

        memory_bytes();
        unmapped_access();
        timer_counting();
        timer_interrupt();
        mailbox_write();
        pipelined_reads();

        $display("errors: %0d mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
wb_pkg.sv
soc_map_pkg.sv
wb_interconnect.sv
memory_2rw_wb.sv
mtime_registers_wb.sv
debug_interface_wb.sv
wb_soc_top.sv
tb_wb_soc.sv

// ==== wb_interconnect.sv ====
`timescale 1ns/1ps

module wb_interconnect
    import wb_pkg::*;
    import soc_map_pkg::*;
#(
    parameter wb_addr_t RESET_VECTOR   = 32'h0001_0000,
    parameter int       MEM_ADDR_WIDTH = 13
)
(
    input  logic     wb_clk_i,
    input  logic     rst_i,

    // instruction master
    input  logic     inst_cyc_i,
    input  logic     inst_stb_i,
    input  wb_addr_t inst_adr_i,
    output wb_data_t inst_dat_o,
    output logic     inst_ack_o,
    output logic     inst_err_o,

    // data master
    input  logic     data_cyc_i,
    input  logic     data_stb_i,
    input  logic     data_we_i,
    input  wb_addr_t data_adr_i,
    input  wb_data_t data_dat_i,
    input  wb_sel_t  data_sel_i,
    output wb_data_t data_dat_o,
    output logic     data_ack_o,
    output logic     data_err_o,

    // gated strobes toward the slaves
    output logic     mem0_stb_o,
    output logic     mem1_stb_o,
    output logic     tmr_stb_o,
    output logic     dbg_stb_o,

    // slave responses
    input  wb_data_t mem0_dat_i,
    input  logic     mem0_ack_i,
    input  wb_data_t mem1_dat_i,
    input  logic     mem1_ack_i,
    input  wb_data_t tmr_dat_i,
    input  logic     tmr_ack_i,
    input  wb_data_t dbg_dat_i,
    input  logic     dbg_ack_i
);

    // last byte of the memory window
    localparam wb_addr_t MEM_LAST = RESET_VECTOR + ((32'd1 << (MEM_ADDR_WIDTH + 2)) - 32'd1);

    logic          inst_req;
    logic          inst_hit;
    logic          inst_sel_q;
    logic          inst_err_q;
    logic          data_req;
    wb_slave_sel_t data_hit;
    wb_slave_sel_t data_sel_q;
    logic          data_err_q;

    function automatic logic in_mem_window(wb_addr_t adr);
        return (adr >= RESET_VECTOR) && (adr <= MEM_LAST);
    endfunction

    assign inst_req = inst_cyc_i && inst_stb_i;
    assign data_req = data_cyc_i && data_stb_i;

    // address decode, at most one hit per port
    assign inst_hit           = in_mem_window(inst_adr_i);
    assign data_hit[SLV_MEM]  = in_mem_window(data_adr_i);
    assign data_hit[SLV_TMR]  = (data_adr_i >= MTIME_BASE) && (data_adr_i <= MTIME_LAST);
    assign data_hit[SLV_DBG]  = (data_adr_i == DEBUG_ADR);
    assign data_hit[SLV_RSVD] = 1'b0;

    assign mem0_stb_o = inst_req && inst_hit;
    assign mem1_stb_o = data_req && data_hit[SLV_MEM];
    assign tmr_stb_o  = data_req && data_hit[SLV_TMR];
    assign dbg_stb_o  = data_req && data_hit[SLV_DBG];

    // selection for the response cycle
    always_ff @(posedge wb_clk_i)
    begin
        if (rst_i)
        begin
            inst_sel_q <= 1'b0;
            inst_err_q <= 1'b0;
            data_sel_q <= '0;
            data_err_q <= 1'b0;
        end
        else
        begin
            inst_sel_q <= mem0_stb_o;
            inst_err_q <= inst_req && !inst_hit;
            data_sel_q <= data_req ? data_hit : '0;
            data_err_q <= data_req && (data_hit == '0);
        end
    end

    // fetch port has memory port 0 as its only slave
    assign inst_dat_o = inst_sel_q ? mem0_dat_i : '0;
    assign inst_ack_o = inst_sel_q && mem0_ack_i;
    assign inst_err_o = inst_err_q;

    // data is zero when nothing is selected, which covers err
    always_comb
    begin
        data_dat_o = '0;
        data_ack_o = 1'b0;
        if (data_sel_q[SLV_MEM])
        begin
            data_dat_o = mem1_dat_i;
            data_ack_o = mem1_ack_i;
        end
        else if (data_sel_q[SLV_TMR])
        begin
            data_dat_o = tmr_dat_i;
            data_ack_o = tmr_ack_i;
        end
        else if (data_sel_q[SLV_DBG])
        begin
            data_dat_o = dbg_dat_i;
            data_ack_o = dbg_ack_i;
        end
    end
    assign data_err_o = data_err_q;

    a_sel_onehot: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        $onehot0(data_sel_q))
        else $error("data slave selection is not one-hot");

    // every slave ack must match a strobe registered the cycle before
    a_no_orphan_ack: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        (({dbg_ack_i, tmr_ack_i, mem1_ack_i} & ~data_sel_q[SLV_DBG:SLV_MEM]) == 3'b000)
        && !(mem0_ack_i && !inst_sel_q))
        else $error("slave ack without a registered strobe");

    // master must present a known word and at least one lane on a write
    a_write_req: assert property (@(posedge wb_clk_i) disable iff (rst_i)
        (data_req && data_we_i) |-> ((data_sel_i != '0) && !$isunknown(data_dat_i)))
        else $error("data write with no byte lanes or unknown data");

endmodule

// ==== wb_pkg.sv ====
package wb_pkg;

    // byte lanes in one bus word
    localparam int WB_DATA_BYTES = 4;

    typedef logic [31:0]                  wb_addr_t;
    typedef logic [8*WB_DATA_BYTES-1:0]   wb_data_t;
    typedef logic [WB_DATA_BYTES-1:0]     wb_sel_t;

    // one-hot slave select on the data port
    typedef logic [3:0] wb_slave_sel_t;

    localparam int SLV_MEM  = 0;
    localparam int SLV_TMR  = 1;
    localparam int SLV_DBG  = 2;
    localparam int SLV_RSVD = 3;

    // replace only the lanes enabled by sel
    function automatic wb_data_t wb_merge_lanes(wb_data_t old_word, wb_data_t wr_word,
                                                wb_sel_t sel);
        wb_data_t merged;
        merged = old_word;
        for (int b = 0; b < WB_DATA_BYTES; b++)
        begin
            if (sel[b])
            begin
                merged[8*b +: 8] = wr_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

// ==== wb_soc_top.sv ====
`timescale 1ns/1ps

module wb_soc_top
    import wb_pkg::*;
#(
    parameter wb_addr_t RESET_VECTOR   = 32'h0001_0000,
    parameter int       MEM_ADDR_WIDTH = 13
)
(
    input  logic     wb_clk_i,
    input  logic     rst_i,

    input  logic     inst_cyc_i,
    input  logic     inst_stb_i,
    input  wb_addr_t inst_adr_i,
    output wb_data_t inst_dat_o,
    output logic     inst_ack_o,
    output logic     inst_err_o,

    input  logic     data_cyc_i,
    input  logic     data_stb_i,
    input  logic     data_we_i,
    input  wb_addr_t data_adr_i,
    input  wb_data_t data_dat_i,
    input  wb_sel_t  data_sel_i,
    output wb_data_t data_dat_o,
    output logic     data_ack_o,
    output logic     data_err_o,

    output logic     mtip_o,
    output wb_data_t dbg_data_o,
    output logic     dbg_valid_o
);

    logic     mem0_stb;
    logic     mem1_stb;
    logic     tmr_stb;
    logic     dbg_stb;
    wb_data_t mem0_dat;
    logic     mem0_ack;
    wb_data_t mem1_dat;
    logic     mem1_ack;
    wb_data_t tmr_dat;
    logic     tmr_ack;
    wb_data_t dbg_dat;
    logic     dbg_ack;

    wb_interconnect #(
        .RESET_VECTOR   (RESET_VECTOR),
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) wb_interconnect_inst (
        .wb_clk_i   (wb_clk_i),
        .rst_i      (rst_i),
        .inst_cyc_i (inst_cyc_i),
        .inst_stb_i (inst_stb_i),
        .inst_adr_i (inst_adr_i),
        .inst_dat_o (inst_dat_o),
        .inst_ack_o (inst_ack_o),
        .inst_err_o (inst_err_o),
        .data_cyc_i (data_cyc_i),
        .data_stb_i (data_stb_i),
        .data_we_i  (data_we_i),
        .data_adr_i (data_adr_i),
        .data_dat_i (data_dat_i),
        .data_sel_i (data_sel_i),
        .data_dat_o (data_dat_o),
        .data_ack_o (data_ack_o),
        .data_err_o (data_err_o),
        .mem0_stb_o (mem0_stb),
        .mem1_stb_o (mem1_stb),
        .tmr_stb_o  (tmr_stb),
        .dbg_stb_o  (dbg_stb),
        .mem0_dat_i (mem0_dat),
        .mem0_ack_i (mem0_ack),
        .mem1_dat_i (mem1_dat),
        .mem1_ack_i (mem1_ack),
        .tmr_dat_i  (tmr_dat),
        .tmr_ack_i  (tmr_ack),
        .dbg_dat_i  (dbg_dat),
        .dbg_ack_i  (dbg_ack)
    );

    // request fields go straight to the slaves, only strobes are gated
    memory_2rw_wb #(
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
    ) memory_inst (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .p0_stb_i (mem0_stb),
        .p0_adr_i (inst_adr_i),
        .p0_dat_o (mem0_dat),
        .p0_ack_o (mem0_ack),
        .p1_stb_i (mem1_stb),
        .p1_we_i  (data_we_i),
        .p1_adr_i (data_adr_i),
        .p1_dat_i (data_dat_i),
        .p1_sel_i (data_sel_i),
        .p1_dat_o (mem1_dat),
        .p1_ack_o (mem1_ack)
    );

    mtime_registers_wb mtime_inst (
        .wb_clk_i (wb_clk_i),
        .rst_i    (rst_i),
        .stb_i    (tmr_stb),
        .we_i     (data_we_i),
        .adr_i    (data_adr_i),
        .dat_i    (data_dat_i),
        .sel_i    (data_sel_i),
        .dat_o    (tmr_dat),
        .ack_o    (tmr_ack),
        .mtip_o   (mtip_o)
    );

    debug_interface_wb debug_inst (
        .wb_clk_i    (wb_clk_i),
        .rst_i       (rst_i),
        .stb_i       (dbg_stb),
        .we_i        (data_we_i),
        .dat_i       (data_dat_i),
        .sel_i       (data_sel_i),
        .dat_o       (dbg_dat),
        .ack_o       (dbg_ack),
        .dbg_data_o  (dbg_data_o),
        .dbg_valid_o (dbg_valid_o)
    );

endmodule
